/* design/conv_types_pkg.sv */
// Datapath widths and line types shared by the convolution engine blocks
`default_nettype none

package conv_types_pkg;

  // elements per line
  localparam int LANES = 8;
  localparam int ELEM_W = 16;
  localparam int ACC_W = 32;

  typedef logic signed [ELEM_W-1:0] elem_t;
  typedef logic signed [ACC_W-1:0] acc_t;

  // packed lines, lane 0 in the low bits
  typedef logic [LANES*ELEM_W-1:0] in_line_t;
  typedef logic [LANES*ACC_W-1:0] out_line_t;

  // life cycle of one kernel bank
  typedef enum logic [1:0] {
    buf_vacant,
    buf_fill,
    buf_full,
    buf_drain
  } buf_status_t;

endpackage

`default_nettype wire

/* design/host_port_pkg.sv */
// Memory port types and read tag encoding used by the fetch and routing logic
`default_nettype none

package host_port_pkg;

  localparam int ADDR_W = 32;
  localparam int TAG_W = 8;

  typedef logic [ADDR_W-1:0] addr_t;
  // bit 0 carries the kind, the rest is zero
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [15:0] count_t;

  localparam logic TAG_IMAGE = 1'b0;
  localparam logic TAG_KERNEL = 1'b1;

endpackage

`default_nettype wire

/* design/buf_read_if.sv */
// Read path from the MAC scheduler into the image store and the kernel banks
`timescale 1ns/10ps
`default_nettype none

interface buf_read_if import conv_types_pkg::*; #(
  parameter int LINE_DEPTH_BITS = 6
);

  logic [LINE_DEPTH_BITS-1:0] rd_line;
  logic rd_bank;
  logic rd_en;
  // drops the selected bank back to vacant
  logic bank_release;

  // registered, valid one cycle after rd_en
  in_line_t image_line;
  in_line_t kernel_line;
  logic image_full;
  logic [1:0] bank_full;

  modport scheduler (
    output rd_line, rd_bank, rd_en, bank_release,
    input image_line, kernel_line, image_full, bank_full
  );

  modport buffers (
    input rd_line, rd_bank, rd_en, bank_release,
    output image_line, kernel_line, image_full, bank_full
  );

endinterface

`default_nettype wire

/* design/fetch_sequencer.sv */
// Issues tagged line reads, the image first and then one kernel per free bank
`timescale 1ns/10ps
`default_nettype none

module fetch_sequencer import host_port_pkg::*; #(
  parameter int LINE_DEPTH_BITS = 6
) (
  input wire logic clk,
  input wire logic reset,
  input wire logic start,
  input wire addr_t image_base,
  input wire addr_t kernel_base,
  input wire count_t num_lines,
  input wire count_t num_kernels,
  input wire logic rd_req_almostfull,
  input wire logic kernel_bank_free,
  output addr_t rd_req_addr,
  output tag_t rd_req_tag,
  output logic rd_req_en
);

  typedef enum logic [2:0] {
    st_idle,
    st_image,
    st_kernel_wait,
    st_kernel,
    st_finished
  } fetch_state_t;

  fetch_state_t state;
  addr_t img_addr;
  addr_t kern_addr;
  count_t lines_q;
  count_t kernels_q;
  count_t line_cnt;
  count_t kern_cnt;
  // free must drop once per burst, so only one kernel is ever in flight
  logic seen_busy;
  logic issuing;

  assign issuing = ((state == st_image) || (state == st_kernel)) && !rd_req_almostfull;
  assign rd_req_en = issuing;
  assign rd_req_addr = (state == st_image) ? img_addr : kern_addr;
  assign rd_req_tag = {{(TAG_W-1){1'b0}}, (state == st_image) ? TAG_IMAGE : TAG_KERNEL};

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      line_cnt <= '0;
      kern_cnt <= '0;
      seen_busy <= 1'b1;
    end else if (start) begin
      state <= st_image;
      img_addr <= image_base;
      kern_addr <= kernel_base;
      lines_q <= num_lines;
      kernels_q <= num_kernels;
      line_cnt <= '0;
      kern_cnt <= '0;
      seen_busy <= 1'b1;
    end else begin
      case (state)
        st_image: begin
          if (issuing) begin
            img_addr <= img_addr + 1;
            line_cnt <= line_cnt + 1;
            if (line_cnt == lines_q - 1) begin
              line_cnt <= '0;
              state <= st_kernel_wait;
            end
          end
        end
        st_kernel_wait: begin
          if (!kernel_bank_free) begin
            seen_busy <= 1'b1;
          end else if (seen_busy) begin
            seen_busy <= 1'b0;
            state <= st_kernel;
          end
        end
        st_kernel: begin
          if (issuing) begin
            kern_addr <= kern_addr + 1;
            line_cnt <= line_cnt + 1;
            if (line_cnt == lines_q - 1) begin
              line_cnt <= '0;
              kern_cnt <= kern_cnt + 1;
              state <= (kern_cnt == kernels_q - 1) ? st_finished : st_kernel_wait;
            end
          end
        end
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/line_buffers.sv */
// Routes read responses into the image store and the ping-pong kernel banks
`timescale 1ns/10ps
`default_nettype none

module line_buffers import conv_types_pkg::*, host_port_pkg::*; #(
  parameter int LINE_DEPTH_BITS = 6
) (
  input wire logic clk,
  input wire logic reset,
  input wire logic start,
  input wire count_t num_lines,
  input wire logic rd_rsp_valid,
  input wire tag_t rd_rsp_tag,
  input wire in_line_t rd_rsp_data,
  output logic kernel_bank_free,
  buf_read_if.buffers bus
);

  localparam int DEPTH = 2 ** LINE_DEPTH_BITS;

  in_line_t image_mem [DEPTH];
  in_line_t kern_mem [2][DEPTH];

  logic rsp_valid_q;
  logic rsp_kind_q;
  in_line_t rsp_data_q;
  logic img_we;
  logic kern_we;
  logic kern_last;
  logic [LINE_DEPTH_BITS:0] img_wptr;
  logic [LINE_DEPTH_BITS:0] kern_wptr;
  logic wr_bank;
  count_t lines_q;
  buf_status_t bank_status [2];

  assign img_we = rsp_valid_q && (rsp_kind_q == TAG_IMAGE);
  assign kern_we = rsp_valid_q && (rsp_kind_q == TAG_KERNEL);
  assign kern_last = (count_t'(kern_wptr) == lines_q - 1);
  // low during any kernel write, so the fetcher sees every burst land
  assign kernel_bank_free = (bank_status[wr_bank] == buf_vacant) && !kern_we;

  // responses are written one cycle after they arrive
  always_ff @(posedge clk) begin
    rsp_data_q <= rd_rsp_data;
    rsp_kind_q <= rd_rsp_tag[0];
    if (reset) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= rd_rsp_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (img_we) begin
      image_mem[img_wptr[LINE_DEPTH_BITS-1:0]] <= rsp_data_q;
    end
    if (kern_we) begin
      kern_mem[wr_bank][kern_wptr[LINE_DEPTH_BITS-1:0]] <= rsp_data_q;
    end
    bus.image_line <= image_mem[bus.rd_line];
    bus.kernel_line <= kern_mem[bus.rd_bank][bus.rd_line];
  end

  always_ff @(posedge clk) begin
    if (reset || start) begin
      img_wptr <= '0;
      kern_wptr <= '0;
      wr_bank <= 1'b0;
      bus.image_full <= 1'b0;
    end else begin
      if (img_we) begin
        img_wptr <= img_wptr + 1;
        if (count_t'(img_wptr) == lines_q - 1) begin
          bus.image_full <= 1'b1;
        end
      end
      if (kern_we) begin
        kern_wptr <= kern_last ? '0 : kern_wptr + 1;
        if (kern_last) begin
          wr_bank <= ~wr_bank;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      lines_q <= num_lines;
    end
  end

  for (genvar b = 0; b < 2; b++) begin : g_bank
    logic filling;
    logic reading;

    assign filling = kern_we && (wr_bank == b);
    assign reading = bus.rd_en && (bus.rd_bank == b);
    assign bus.bank_full[b] = (bank_status[b] == buf_full);

    always_ff @(posedge clk) begin
      if (reset || start) begin
        bank_status[b] <= buf_vacant;
      end else begin
        case (bank_status[b])
          buf_vacant: if (filling) bank_status[b] <= kern_last ? buf_full : buf_fill;
          buf_fill: if (filling && kern_last) bank_status[b] <= buf_full;
          // a one-line pass releases on its first read
          buf_full: if (reading) bank_status[b] <= bus.bank_release ? buf_vacant : buf_drain;
          buf_drain: if (reading && bus.bank_release) bank_status[b] <= buf_vacant;
          default: bank_status[b] <= buf_vacant;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* design/mac_scheduler.sv */
// Walks the kernels over the image, one burst of line pairs per kernel bank
`timescale 1ns/10ps
`default_nettype none

module mac_scheduler import host_port_pkg::*; #(
  parameter int LINE_DEPTH_BITS = 6
) (
  input wire logic clk,
  input wire logic reset,
  input wire logic start,
  input wire count_t num_lines,
  input wire count_t num_kernels,
  input wire logic result_room,
  buf_read_if.scheduler bus,
  output logic beat_valid
);

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_gap
  } exec_state_t;

  exec_state_t state;
  count_t lines_q;
  count_t kernels_q;
  count_t line_cnt;
  count_t kern_cnt;
  logic cur_bank;
  logic last_line;
  logic ready;

  assign last_line = (line_cnt == lines_q - 1);
  assign ready = (kern_cnt != kernels_q) && bus.image_full && bus.bank_full[cur_bank]
                 && result_room;

  assign bus.rd_en = (state == st_run);
  assign bus.rd_line = line_cnt[LINE_DEPTH_BITS-1:0];
  assign bus.rd_bank = cur_bank;
  assign bus.bank_release = (state == st_run) && last_line;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      cur_bank <= 1'b0;
      line_cnt <= '0;
      kern_cnt <= '0;
      kernels_q <= '0;
      beat_valid <= 1'b0;
    end else begin
      // read data lands one cycle after rd_en
      beat_valid <= bus.rd_en;
      if (start) begin
        state <= st_idle;
        cur_bank <= 1'b0;
        line_cnt <= '0;
        kern_cnt <= '0;
        lines_q <= num_lines;
        kernels_q <= num_kernels;
      end else begin
        case (state)
          st_idle: begin
            line_cnt <= '0;
            if (ready) state <= st_run;
          end
          st_run: begin
            line_cnt <= line_cnt + 1;
            if (last_line) begin
              cur_bank <= ~cur_bank;
              kern_cnt <= kern_cnt + 1;
              state <= st_gap;
            end
          end
          // drops beat_valid between passes so each sum is framed
          st_gap: state <= st_idle;
          default: state <= st_idle;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* design/lane_mac_array.sv */
// Lane-wise multiply and accumulate, one sum per burst of valid beats
`timescale 1ns/10ps
`default_nettype none

module lane_mac_array import conv_types_pkg::*; (
  input wire logic clk,
  input wire logic reset,
  input wire logic beat_valid,
  input wire in_line_t image_line,
  input wire in_line_t kernel_line,
  output out_line_t result,
  output logic result_valid
);

  acc_t prod [LANES];
  acc_t acc [LANES];
  logic prod_valid;
  logic prod_valid_q;
  logic burst_start;

  assign burst_start = prod_valid && !prod_valid_q;
  // falling edge of the product burst, sums are final here
  assign result_valid = !prod_valid && prod_valid_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid <= 1'b0;
      prod_valid_q <= 1'b0;
    end else begin
      prod_valid <= beat_valid;
      prod_valid_q <= prod_valid;
    end
  end

  for (genvar l = 0; l < LANES; l++) begin : g_lane
    elem_t a;
    elem_t b;

    assign a = elem_t'(image_line[l*ELEM_W +: ELEM_W]);
    assign b = elem_t'(kernel_line[l*ELEM_W +: ELEM_W]);
    assign result[l*ACC_W +: ACC_W] = acc[l];

    always_ff @(posedge clk) begin
      prod[l] <= acc_t'(a * b);
      if (burst_start) begin
        acc[l] <= prod[l];
      end else if (prod_valid) begin
        acc[l] <= acc[l] + prod[l];
      end
    end
  end

endmodule

`default_nettype wire

/* design/sync_fifo.sv */
// Small first-word-fall-through FIFO with an occupancy count
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
  parameter int FIFO_DEPTH_BITS = 2,
  parameter int WIDTH = 32
) (
  input wire logic clk,
  input wire logic reset,
  input wire logic [WIDTH-1:0] din,
  input wire logic we,
  input wire logic re,
  output logic [WIDTH-1:0] dout,
  output logic empty,
  output logic [FIFO_DEPTH_BITS:0] count
);

  logic [WIDTH-1:0] mem [2**FIFO_DEPTH_BITS];
  // one extra bit tells full from empty
  logic [FIFO_DEPTH_BITS:0] wptr;
  logic [FIFO_DEPTH_BITS:0] rptr;

  assign count = wptr - rptr;
  assign empty = (count == '0);
  assign dout = mem[rptr[FIFO_DEPTH_BITS-1:0]];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wptr[FIFO_DEPTH_BITS-1:0]] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wptr <= '0;
      rptr <= '0;
    end else begin
      if (we) wptr <= wptr + 1;
      if (re && !empty) rptr <= rptr + 1;
    end
  end

endmodule

`default_nettype wire

/* design/result_writer.sv */
// Buffers result lines and writes them out in order, then raises done
`timescale 1ns/10ps
`default_nettype none

module result_writer import conv_types_pkg::*, host_port_pkg::*; #(
  parameter int FIFO_DEPTH_BITS = 2
) (
  input wire logic clk,
  input wire logic reset,
  input wire logic start,
  input wire addr_t dest_base,
  input wire count_t num_kernels,
  input wire out_line_t result,
  input wire logic result_valid,
  input wire logic wr_req_almostfull,
  output logic result_room,
  output addr_t wr_req_addr,
  output out_line_t wr_req_data,
  output logic wr_req_en,
  output logic done
);

  typedef enum logic {
    st_idle,
    st_write
  } write_state_t;

  write_state_t state;
  logic fifo_empty;
  logic [FIFO_DEPTH_BITS:0] fifo_count;
  count_t kernels_q;
  count_t written;

  // keeps two slots for passes still in the MAC pipeline
  assign result_room = (fifo_count <= (2 ** FIFO_DEPTH_BITS) - 2);
  assign wr_req_en = (state == st_write) && !fifo_empty && !wr_req_almostfull;

  sync_fifo #(
    .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS),
    .WIDTH($bits(out_line_t))
  ) result_fifo (
    .clk(clk),
    .reset(reset),
    .din(result),
    .we(result_valid),
    .re(wr_req_en),
    .dout(wr_req_data),
    .empty(fifo_empty),
    .count(fifo_count)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      done <= 1'b0;
      written <= '0;
    end else if (start) begin
      state <= st_write;
      done <= 1'b0;
      written <= '0;
      wr_req_addr <= dest_base;
      kernels_q <= num_kernels;
    end else if (wr_req_en) begin
      wr_req_addr <= wr_req_addr + 1;
      written <= written + 1;
      if (written == kernels_q - 1) begin
        state <= st_idle;
        done <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/conv_top.sv */
// Top level of the convolution offload engine, connects job and memory ports to the blocks
`timescale 1ns/10ps
`default_nettype none

module conv_top import conv_types_pkg::*, host_port_pkg::*; #(
  parameter int LINE_DEPTH_BITS = 6,
  parameter int FIFO_DEPTH_BITS = 2
) (
  input wire logic clk,
  input wire logic reset,
  input wire logic start,
  input wire addr_t image_base,
  input wire addr_t kernel_base,
  input wire addr_t dest_base,
  input wire count_t num_lines,
  input wire count_t num_kernels,
  output addr_t rd_req_addr,
  output tag_t rd_req_tag,
  output logic rd_req_en,
  input wire logic rd_req_almostfull,
  input wire logic rd_rsp_valid,
  input wire tag_t rd_rsp_tag,
  input wire in_line_t rd_rsp_data,
  output addr_t wr_req_addr,
  output out_line_t wr_req_data,
  output logic wr_req_en,
  input wire logic wr_req_almostfull,
  output logic done
);

  logic kernel_bank_free;
  logic result_room;
  logic beat_valid;
  out_line_t result;
  logic result_valid;

  buf_read_if #(.LINE_DEPTH_BITS(LINE_DEPTH_BITS)) buf_bus ();

  fetch_sequencer #(.LINE_DEPTH_BITS(LINE_DEPTH_BITS)) fetch_i (
    .clk(clk), .reset(reset), .start(start),
    .image_base(image_base), .kernel_base(kernel_base),
    .num_lines(num_lines), .num_kernels(num_kernels),
    .rd_req_almostfull(rd_req_almostfull), .kernel_bank_free(kernel_bank_free),
    .rd_req_addr(rd_req_addr), .rd_req_tag(rd_req_tag), .rd_req_en(rd_req_en)
  );

  line_buffers #(.LINE_DEPTH_BITS(LINE_DEPTH_BITS)) buffers_i (
    .clk(clk), .reset(reset), .start(start), .num_lines(num_lines),
    .rd_rsp_valid(rd_rsp_valid), .rd_rsp_tag(rd_rsp_tag), .rd_rsp_data(rd_rsp_data),
    .kernel_bank_free(kernel_bank_free), .bus(buf_bus.buffers)
  );

  mac_scheduler #(.LINE_DEPTH_BITS(LINE_DEPTH_BITS)) sched_i (
    .clk(clk), .reset(reset), .start(start),
    .num_lines(num_lines), .num_kernels(num_kernels), .result_room(result_room),
    .bus(buf_bus.scheduler), .beat_valid(beat_valid)
  );

  lane_mac_array mac_i (
    .clk(clk), .reset(reset), .beat_valid(beat_valid),
    .image_line(buf_bus.image_line), .kernel_line(buf_bus.kernel_line),
    .result(result), .result_valid(result_valid)
  );

  result_writer #(.FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)) writer_i (
    .clk(clk), .reset(reset), .start(start),
    .dest_base(dest_base), .num_kernels(num_kernels),
    .result(result), .result_valid(result_valid),
    .wr_req_almostfull(wr_req_almostfull), .result_room(result_room),
    .wr_req_addr(wr_req_addr), .wr_req_data(wr_req_data),
    .wr_req_en(wr_req_en), .done(done)
  );

endmodule

`default_nettype wire

/* sim/host_mem_model.sv */
// Memory model that the testbench connects to the DUT to answer tagged reads and record writes
`timescale 1ns/10ps
`default_nettype none

module host_mem_model import conv_types_pkg::*, host_port_pkg::*; #(
  parameter int MEM_LINES = 1024,
  parameter int MAX_DELAY = 6
) (
  input wire logic clk,
  input wire logic reset,
  input wire addr_t rd_req_addr,
  input wire tag_t rd_req_tag,
  input wire logic rd_req_en,
  output logic rd_req_almostfull,
  output logic rd_rsp_valid,
  output tag_t rd_rsp_tag,
  output in_line_t rd_rsp_data,
  input wire addr_t wr_req_addr,
  input wire out_line_t wr_req_data,
  input wire logic wr_req_en,
  output logic wr_req_almostfull
);

  in_line_t mem [MEM_LINES];
  out_line_t result_mem [MEM_LINES];

  // pending reads are answered strictly in request order
  addr_t pend_addr [$];
  tag_t pend_tag [$];
  longint pend_due [$];
  longint cycle;
  longint last_due;

  task automatic fill_random();
    for (int a = 0; a < MEM_LINES; a++) begin
      mem[a] = {$urandom, $urandom, $urandom, $urandom};
    end
  endtask

  initial begin
    rd_req_almostfull = 1'b0;
    wr_req_almostfull = 1'b0;
    rd_rsp_valid = 1'b0;
    rd_rsp_tag = '0;
    rd_rsp_data = '0;
    cycle = 0;
    last_due = 0;
  end

  // requests and writes are taken on the rising edge
  always @(posedge clk) begin
    longint due;
    cycle = cycle + 1;
    if (!reset && rd_req_en) begin
      due = cycle + 1 + ($urandom % MAX_DELAY);
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      pend_addr.push_back(rd_req_addr);
      pend_tag.push_back(rd_req_tag);
      pend_due.push_back(due);
    end
    if (!reset && wr_req_en) begin
      result_mem[wr_req_addr % MEM_LINES] = wr_req_data;
    end
  end

  // responses and back-pressure change on the falling edge
  always @(negedge clk) begin
    addr_t addr;
    if (reset) begin
      rd_req_almostfull = 1'b0;
      wr_req_almostfull = 1'b0;
      rd_rsp_valid = 1'b0;
    end else begin
      rd_req_almostfull = (($urandom % 4) == 0);
      wr_req_almostfull = (($urandom % 4) == 0);
      rd_rsp_valid = 1'b0;
      if ((pend_due.size() > 0) && (pend_due[0] <= cycle + 1)) begin
        addr = pend_addr.pop_front();
        rd_rsp_valid = 1'b1;
        rd_rsp_tag = pend_tag.pop_front();
        rd_rsp_data = mem[addr % MEM_LINES];
        void'(pend_due.pop_front());
      end
    end
  end

endmodule

`default_nettype wire

/* sim/tb_conv_top.sv */
// Testbench for the convolution engine, runs three jobs against the memory model and checks them
`timescale 1ns/10ps
`default_nettype none

module tb_conv_top import conv_types_pkg::*, host_port_pkg::*; ();

  localparam int PERIOD = 40;
  localparam int SEED = 73628;
  localparam int MAX_DELAY = 6;
  localparam int MEM_LINES = 1024;
  localparam int MAX_KERNELS = 8;
  localparam int NUM_JOBS = 3;
  localparam int JOB_LINES [NUM_JOBS] = '{5, 16, 64};
  localparam int JOB_KERNELS [NUM_JOBS] = '{1, 5, 3};
  localparam int JOB_IMAGE [NUM_JOBS] = '{16, 128, 300};
  localparam int JOB_KERNEL [NUM_JOBS] = '{64, 200, 400};
  localparam int JOB_DEST [NUM_JOBS] = '{900, 910, 920};

  logic clk;
  logic reset;
  logic start;
  addr_t image_base;
  addr_t kernel_base;
  addr_t dest_base;
  count_t num_lines;
  count_t num_kernels;
  addr_t rd_req_addr;
  tag_t rd_req_tag;
  logic rd_req_en;
  logic rd_req_almostfull;
  logic rd_rsp_valid;
  tag_t rd_rsp_tag;
  in_line_t rd_rsp_data;
  addr_t wr_req_addr;
  out_line_t wr_req_data;
  logic wr_req_en;
  logic wr_req_almostfull;
  logic done;

  // job under test and the checker's running state
  int cur_n;
  int cur_k;
  addr_t cur_ib;
  addr_t cur_kb;
  addr_t cur_db;
  out_line_t expected [MAX_KERNELS];
  bit requested [MEM_LINES];
  int rd_count;
  int wr_idx;
  bit start_seen;
  bit done_seen;

  conv_top dut_i (
    .clk(clk), .reset(reset), .start(start),
    .image_base(image_base), .kernel_base(kernel_base), .dest_base(dest_base),
    .num_lines(num_lines), .num_kernels(num_kernels),
    .rd_req_addr(rd_req_addr), .rd_req_tag(rd_req_tag), .rd_req_en(rd_req_en),
    .rd_req_almostfull(rd_req_almostfull),
    .rd_rsp_valid(rd_rsp_valid), .rd_rsp_tag(rd_rsp_tag), .rd_rsp_data(rd_rsp_data),
    .wr_req_addr(wr_req_addr), .wr_req_data(wr_req_data), .wr_req_en(wr_req_en),
    .wr_req_almostfull(wr_req_almostfull), .done(done)
  );

  host_mem_model #(.MEM_LINES(MEM_LINES), .MAX_DELAY(MAX_DELAY)) mem_i (
    .clk(clk), .reset(reset),
    .rd_req_addr(rd_req_addr), .rd_req_tag(rd_req_tag), .rd_req_en(rd_req_en),
    .rd_req_almostfull(rd_req_almostfull),
    .rd_rsp_valid(rd_rsp_valid), .rd_rsp_tag(rd_rsp_tag), .rd_rsp_data(rd_rsp_data),
    .wr_req_addr(wr_req_addr), .wr_req_data(wr_req_data), .wr_req_en(wr_req_en),
    .wr_req_almostfull(wr_req_almostfull)
  );

  always #(PERIOD / 2) clk = ~clk;

  task automatic stop_with_failure();
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_mismatch(string name, logic [255:0] got, logic [255:0] exp);
    $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    stop_with_failure();
  endtask

  task automatic report_error(string what);
    $display("Error at %0t: %s", $time, what);
    stop_with_failure();
  endtask

  // reads plus writes over all jobs
  function automatic int total_requests();
    int total = 0;
    for (int j = 0; j < NUM_JOBS; j++) begin
      total += JOB_LINES[j] * (JOB_KERNELS[j] + 1) + JOB_KERNELS[j];
    end
    return total;
  endfunction

  // lane-wise dot product of the image with kernel k, wrapping at 32 bits
  function automatic out_line_t reference_line(int k);
    out_line_t line;
    in_line_t img;
    in_line_t kern;
    int sum;
    int a;
    int b;
    line = '0;
    for (int l = 0; l < LANES; l++) begin
      sum = 0;
      for (int i = 0; i < cur_n; i++) begin
        img = mem_i.mem[cur_ib + i];
        kern = mem_i.mem[cur_kb + k * cur_n + i];
        a = elem_t'(img[l*ELEM_W +: ELEM_W]);
        b = elem_t'(kern[l*ELEM_W +: ELEM_W]);
        sum += a * b;
      end
      line[l*ACC_W +: ACC_W] = sum;
    end
    return line;
  endfunction

  task automatic check_read();
    bit in_image;
    bit in_kernel;
    in_image = (rd_req_addr >= cur_ib) && (rd_req_addr < cur_ib + cur_n);
    in_kernel = (rd_req_addr >= cur_kb) && (rd_req_addr < cur_kb + cur_n * cur_k);
    assert (!rd_req_almostfull)
      else report_error("read request issued while rd_req_almostfull was high");
    assert (in_image || in_kernel)
      else report_error($sformatf("read of line %0h outside the job regions", rd_req_addr));
    assert (rd_req_tag == tag_t'(in_kernel))
      else report_mismatch("rd_req_tag", rd_req_tag, tag_t'(in_kernel));
    assert (!requested[rd_req_addr])
      else report_error($sformatf("line %0h requested twice", rd_req_addr));
    requested[rd_req_addr] = 1'b1;
    rd_count++;
  endtask

  task automatic check_write();
    assert (!wr_req_almostfull)
      else report_error("write request issued while wr_req_almostfull was high");
    assert (wr_idx < cur_k)
      else report_error("more result writes than kernels in the job");
    assert (wr_req_addr == cur_db + wr_idx)
      else report_mismatch("wr_req_addr", wr_req_addr, cur_db + wr_idx);
    assert (wr_req_data == expected[wr_idx])
      else report_mismatch("wr_req_data", wr_req_data, expected[wr_idx]);
    wr_idx++;
  endtask

  task automatic check_done();
    if (done) begin
      assert (wr_idx == cur_k)
        else report_error("done rose before the last result write");
    end
    if (done_seen) begin
      assert (done)
        else report_error("done dropped before the next start");
    end
    done_seen = done;
  endtask

  // checks run on the rising edge, where the DUT samples its inputs
  always @(posedge clk) begin
    if (!reset) begin
      if (!start_seen) begin
        assert (!rd_req_en) else report_mismatch("rd_req_en", rd_req_en, 0);
        assert (!wr_req_en) else report_mismatch("wr_req_en", wr_req_en, 0);
        assert (!done) else report_mismatch("done", done, 0);
      end
      if (start) begin
        start_seen = 1'b1;
        done_seen = 1'b0;
        rd_count = 0;
        wr_idx = 0;
        foreach (requested[a]) begin
          requested[a] = 1'b0;
        end
      end else begin
        if (rd_req_en) check_read();
        if (wr_req_en) check_write();
        check_done();
      end
    end
  end

  task automatic run_job(int j);
    @(negedge clk);
    cur_n = JOB_LINES[j];
    cur_k = JOB_KERNELS[j];
    cur_ib = addr_t'(JOB_IMAGE[j]);
    cur_kb = addr_t'(JOB_KERNEL[j]);
    cur_db = addr_t'(JOB_DEST[j]);
    for (int k = 0; k < cur_k; k++) begin
      expected[k] = reference_line(k);
    end
    image_base = cur_ib;
    kernel_base = cur_kb;
    dest_base = cur_db;
    num_lines = count_t'(cur_n);
    num_kernels = count_t'(cur_k);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (!done) @(negedge clk);
    assert (rd_count == cur_n * (cur_k + 1))
      else report_mismatch("read request count", rd_count, cur_n * (cur_k + 1));
    for (int k = 0; k < cur_k; k++) begin
      assert (mem_i.result_mem[cur_db + k] == expected[k])
        else report_mismatch("recorded result line", mem_i.result_mem[cur_db + k], expected[k]);
    end
    // let done sit high for a while before the next job
    repeat (4) @(negedge clk);
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    void'($urandom(SEED));
    clk = 1'b0;
    reset = 1'b1;
    start = 1'b0;
    image_base = '0;
    kernel_base = '0;
    dest_base = '0;
    num_lines = '0;
    num_kernels = '0;
    cur_n = 0;
    cur_k = 0;
    cur_ib = '0;
    cur_kb = '0;
    cur_db = '0;
    rd_count = 0;
    wr_idx = 0;
    start_seen = 1'b0;
    done_seen = 1'b0;
    mem_i.fill_random();
    repeat (4) @(negedge clk);
    reset = 1'b0;
    repeat (3) @(negedge clk);
    for (int j = 0; j < NUM_JOBS; j++) begin
      run_job(j);
    end
    $display("Simulation completed successfully");
    $finish;
  end

  // bound on the whole run, every request waiting the longest delay four times over
  initial begin
    #(4.0 * total_requests() * MAX_DELAY * PERIOD);
    $display("Timeout at %0t, the jobs did not finish", $time);
    stop_with_failure();
  end

endmodule

`default_nettype wire

/* project.f */
design/conv_types_pkg.sv
design/host_port_pkg.sv
design/buf_read_if.sv
design/fetch_sequencer.sv
design/line_buffers.sv
design/mac_scheduler.sv
design/lane_mac_array.sv
design/sync_fifo.sv
design/result_writer.sv
design/conv_top.sv
sim/host_mem_model.sv
sim/tb_conv_top.sv

/* Bender.yml */
package:
  name: conv_offload

sources:
  - files:
      - design/conv_types_pkg.sv
      - design/host_port_pkg.sv
      - design/buf_read_if.sv
      - design/fetch_sequencer.sv
      - design/line_buffers.sv
      - design/mac_scheduler.sv
      - design/lane_mac_array.sv
      - design/sync_fifo.sv
      - design/result_writer.sv
      - design/conv_top.sv
  - target: simulation
    files:
      - sim/host_mem_model.sv
      - sim/tb_conv_top.sv
